//--- vlog.f
lc3b_types.sv
lc3b_regfile.sv
lc3b_decode.sv
id_ex_latch.sv
lc3b_alu.sv
execute.sv
lc3b_exec_top.sv
tb_clock_gen.sv
tb_lc3b_exec.sv

//--- Bender.yml
package:
  name: lc3b_exec

sources:
  - lc3b_types.sv
  - lc3b_regfile.sv
  - lc3b_decode.sv
  - id_ex_latch.sv
  - lc3b_alu.sv
  - execute.sv
  - lc3b_exec_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_lc3b_exec.sv

//--- tb_lc3b_exec.sv
module tb_lc3b_exec;
    import lc3b_types::*;

    localparam int n_random = 200;

    logic     clk;
    logic     reset;
    lc3b_word instr;
    lc3b_word npc;
    logic     instr_valid;
    logic     mem_stall;
    lc3b_word mem_rdata;
    lc3b_word mem_addr;
    lc3b_word mem_wdata;
    logic     mem_read;
    logic     mem_write;
    logic     wb_valid;
    lc3b_reg  wb_reg;
    lc3b_word wb_data;
    lc3b_nzp  cc;
    logic     stall;

    lc3b_word mem [64];
    lc3b_word prog [$];
    lc3b_word ref_regs [8];
    lc3b_nzp  ref_cc;
    logic     ex_full;
    logic     ex_second;
    lc3b_word ex_ir;
    lc3b_word ex_npc;
    lc3b_word saved_ptr;
    lc3b_word src1;
    lc3b_word operand;
    lc3b_word ea6;
    logic     exp_read;
    logic     exp_write;
    logic     exp_wb;
    logic     exp_cc_load;
    logic     exp_ptr_cycle;
    lc3b_word exp_addr;
    lc3b_word exp_wdata;
    lc3b_reg  exp_wb_reg;
    lc3b_word exp_wb_data;
    int       dut_retired = 0;
    int       expected_retired = 0;
    int       cycle_count = 0;
    int       cycle_limit = 0;

    tb_clock_gen #(.half_period(2), .reset_cycles(10)) clock_gen
    (
        .clk   (clk),
        .reset (reset)
    );

    lc3b_exec_top #(.cc_init(3'b010)) dut (.*);

    assign mem_rdata = mem[mem_addr[6:1]];      // word memory, answers in the same cycle.

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "run stopped after an error.");
    endtask

    task automatic fail_value(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        abort_run();
    endtask

    function automatic lc3b_word sext(input lc3b_word v, input int bits);
        lc3b_word t;
        t = v << (16 - bits);
        return $signed(t) >>> (16 - bits);
    endfunction

    function automatic lc3b_nzp nzp_of(input lc3b_word v);
        if (v[15])
            return 3'b100;
        if (v == 16'h0000)
            return 3'b010;
        return 3'b001;
    endfunction

    function automatic lc3b_word shifted(input lc3b_word v, input logic [5:0] low6);
        lc3b_word r;
        r = v;
        for (int i = 0; i < int'(low6[3:0]); i++)
        begin
            if (!low6[4])
                r = {r[14:0], 1'b0};
            else
                r = {low6[5] & r[15], r[15:1]};     // bit 5 selects the sign fill.
        end
        return r;
    endfunction

    function automatic bit is_supported(input logic [3:0] op);
        case (op)
            op_add, op_and, op_not, op_shf, op_lea, op_ldr, op_str, op_ldi, op_sti:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic lc3b_word rr_word(input logic [3:0] op, input lc3b_reg dr,
                                         input lc3b_reg sr1, input logic imm,
                                         input logic [4:0] v);
        return {op, dr, sr1, imm, v};
    endfunction

    function automatic lc3b_word offset_word(input logic [3:0] op, input lc3b_reg r,
                                             input lc3b_reg base, input logic [5:0] off);
        return {op, r, base, off};
    endfunction

    function automatic lc3b_word shift_word(input lc3b_reg dr, input lc3b_reg sr,
                                            input logic a, input logic d,
                                            input logic [3:0] amount);
        return {op_shf, dr, sr, a, d, amount};
    endfunction

    function automatic lc3b_word random_instr();
        logic [11:0] low;
        logic [3:0]  op;
        low = 12'($urandom);
        case ($urandom % 11)
            0:       op = op_add;
            1:       op = op_and;
            2:       op = op_not;
            3:       op = op_shf;
            4:       op = op_lea;
            5:       op = op_ldr;
            6:       op = op_str;
            7:       op = op_ldi;
            8:       op = op_sti;
            default:
            begin
                op = 4'($urandom);
                while (is_supported(op))
                    op = 4'($urandom);
            end
        endcase
        return {op, low};
    endfunction

    task automatic build_program();
        prog.push_back(rr_word(op_add, 3'd1, 3'd0, 1'b1, 5'd7));
        prog.push_back(rr_word(op_add, 3'd2, 3'd1, 1'b1, 5'h1d));  // depends on the add before.
        prog.push_back(rr_word(op_add, 3'd3, 3'd1, 1'b0, 5'd2));
        prog.push_back(rr_word(op_and, 3'd4, 3'd3, 1'b0, 5'd1));
        prog.push_back(rr_word(op_and, 3'd5, 3'd3, 1'b1, 5'h10));  // result is zero.
        prog.push_back(offset_word(op_not, 3'd6, 3'd5, 6'h3f));
        prog.push_back(shift_word(3'd7, 3'd6, 1'b0, 1'b0, 4'd3));
        prog.push_back(shift_word(3'd7, 3'd7, 1'b0, 1'b1, 4'd2));
        prog.push_back(shift_word(3'd7, 3'd6, 1'b1, 1'b1, 4'd5));
        prog.push_back({op_lea, 3'd1, 9'h1f0});
        prog.push_back(offset_word(op_ldr, 3'd2, 3'd1, 6'h05));
        prog.push_back(offset_word(op_str, 3'd2, 3'd3, 6'h3e));
        prog.push_back(offset_word(op_ldr, 3'd4, 3'd3, 6'h3e));    // reads back the store.
        prog.push_back(offset_word(op_ldi, 3'd5, 3'd1, 6'h02));
        prog.push_back(offset_word(op_sti, 3'd5, 3'd2, 6'h01));
        prog.push_back(offset_word(op_ldi, 3'd6, 3'd2, 6'h01));    // same pointer as the sti.
        prog.push_back(16'h0e05);
        prog.push_back(16'hc1c0);
        prog.push_back(16'hf025);
        prog.push_back(rr_word(op_add, 3'd0, 3'd6, 1'b1, 5'd0));
        for (int i = 0; i < n_random; i++)
            prog.push_back(random_instr());
    endtask

    task automatic idle_cycle();
        instr_valid = 1'b0;
        mem_stall = ($urandom % 4) == 0;
        @(negedge clk);
    endtask

    // holds the instruction until a rising edge takes it.
    task automatic issue(input lc3b_word word, input lc3b_word pc);
        logic taken;
        instr = word;
        npc = pc;
        instr_valid = 1'b1;
        taken = 1'b0;
        while (!taken)
        begin
            mem_stall = ($urandom % 4) == 0;
            #1;
            taken = !stall;
            @(negedge clk);
        end
    endtask

    always_comb
    begin
        exp_read = 1'b0;
        exp_write = 1'b0;
        exp_wb = 1'b0;
        exp_cc_load = 1'b0;
        exp_ptr_cycle = 1'b0;
        exp_addr = '0;
        exp_wdata = ref_regs[ex_ir[11:9]];
        exp_wb_reg = ex_ir[11:9];
        exp_wb_data = '0;
        src1 = ref_regs[ex_ir[8:6]];
        ea6 = src1 + (sext(ex_ir[5:0], 6) << 1);
        operand = ex_ir[5] ? sext(ex_ir[4:0], 5) : ref_regs[ex_ir[2:0]];
        if (ex_full)
        begin
            case (ex_ir[15:12])
                op_add, op_and, op_not, op_shf:
                begin
                    exp_wb = 1'b1;
                    exp_cc_load = 1'b1;
                    case (ex_ir[15:12])
                        op_add:  exp_wb_data = src1 + operand;
                        op_and:  exp_wb_data = src1 & operand;
                        op_not:  exp_wb_data = ~src1;
                        default: exp_wb_data = shifted(src1, ex_ir[5:0]);
                    endcase
                end
                op_lea:
                begin
                    exp_wb = 1'b1;
                    exp_wb_data = ex_npc + (sext(ex_ir[8:0], 9) << 1);
                end
                op_ldr:
                begin
                    exp_read = 1'b1;
                    exp_addr = ea6;
                    exp_wb = 1'b1;
                    exp_cc_load = 1'b1;
                    exp_wb_data = mem[ea6[6:1]];
                end
                op_str:
                begin
                    exp_write = 1'b1;
                    exp_addr = ea6;
                end
                op_ldi, op_sti:
                begin
                    exp_addr = ex_second ? saved_ptr : ea6;
                    exp_ptr_cycle = !ex_second;
                    exp_read = !ex_second || ex_ir[15:12] == op_ldi;
                    exp_write = ex_second && ex_ir[15:12] == op_sti;
                    exp_wb = ex_second && ex_ir[15:12] == op_ldi;
                    exp_cc_load = exp_wb;
                    exp_wb_data = mem[saved_ptr[6:1]];
                end
                default: ;
            endcase
        end
    end

    // the model's execute slot follows the pipeline timing, not the DUT.
    always @(posedge clk)
    begin
        if (reset)
        begin
            ex_full <= 1'b0;
            ex_second <= 1'b0;
            ref_cc <= 3'b010;
            for (int i = 0; i < 8; i++)
                ref_regs[i] <= '0;
        end
        else
        begin
            if (!mem_stall)
            begin
                if (exp_wb)
                    ref_regs[exp_wb_reg] <= exp_wb_data;
                if (exp_cc_load)
                    ref_cc <= nzp_of(exp_wb_data);
                if (exp_ptr_cycle)
                    saved_ptr <= mem[exp_addr[6:1]];
                ex_second <= exp_ptr_cycle;
            end
            if (!(mem_stall || exp_ptr_cycle))
            begin
                ex_full <= instr_valid;
                ex_ir <= instr;
                ex_npc <= npc;
            end
        end
    end

    always @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 64; i++)
                mem[i] <= lc3b_word'(i * 16'h9e37) ^ 16'h5a5a;
        end
        else
        begin
            if (mem_write && !mem_stall)
                mem[mem_addr[6:1]] <= mem_wdata;
            if (wb_valid || (mem_write && !mem_stall))
                dut_retired <= dut_retired + 1;
        end
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            abort_run();
        end
    end

    a_reset_state: assert property (@(posedge clk)
        reset |=> (!mem_read && !mem_write && !wb_valid && !stall && cc == 3'b010))
        else fail_value("outputs are not idle after reset");

    a_strobes: assert property (@(posedge clk) disable iff (reset)
        mem_read == exp_read && mem_write == exp_write)
        else fail_value("memory strobes differ from the model");

    a_addr: assert property (@(posedge clk) disable iff (reset)
        (exp_read || exp_write) |-> mem_addr == exp_addr)
        else fail_value($sformatf("mem_addr %h, expected %h",
                                  $sampled(mem_addr), $sampled(exp_addr)));

    a_wdata: assert property (@(posedge clk) disable iff (reset)
        exp_write |-> mem_wdata == exp_wdata)
        else fail_value("store data differs from the source register");

    a_wb_valid: assert property (@(posedge clk) disable iff (reset)
        wb_valid == (exp_wb && !mem_stall))
        else fail_value("writeback strobe differs from the model");

    a_wb_value: assert property (@(posedge clk) disable iff (reset)
        wb_valid |-> wb_reg == exp_wb_reg && wb_data == exp_wb_data)
        else fail_value($sformatf("wb r%0d = %h, expected r%0d = %h",
                                  $sampled(wb_reg), $sampled(wb_data),
                                  $sampled(exp_wb_reg), $sampled(exp_wb_data)));

    a_stall: assert property (@(posedge clk) disable iff (reset)
        stall == (mem_stall || exp_ptr_cycle))
        else fail_value("stall differs from the model");

    a_hold: assert property (@(posedge clk) disable iff (reset)
        mem_stall && (mem_read || mem_write)
            |=> $stable(mem_addr) && $stable(mem_read) && $stable(mem_write))
        else fail_value("memory access changed during a memory stall");

    a_cc: assert property (@(posedge clk) disable iff (reset) cc == ref_cc)
        else fail_value($sformatf("cc %b, expected %b", $sampled(cc), $sampled(ref_cc)));

    initial
    begin
        void'($urandom(91790));
        instr = '0;
        npc = '0;
        instr_valid = 1'b0;
        mem_stall = 1'b0;
        build_program();
        cycle_limit = 40 * prog.size() + 200;
        @(negedge reset);
        @(negedge clk);
        foreach (prog[i])
        begin
            if ($urandom % 8 == 0)
                idle_cycle();
            issue(prog[i], 16'h3000 + 16'(2 * i));
            if (is_supported(prog[i][15:12]))
                expected_retired++;
        end
        instr_valid = 1'b0;
        mem_stall = 1'b0;
        while (dut_retired < expected_retired)
            @(negedge clk);
        repeat (4) @(negedge clk);
        a_retired: assert (dut_retired == expected_retired)
            else fail_value($sformatf("%0d instructions retired, expected %0d",
                                      dut_retired, expected_retired));
        $display("Result: PASSED");
        $finish;
    end

endmodule : tb_lc3b_exec

//--- tb_clock_gen.sv
module tb_clock_gen
#(
    parameter int half_period  = 2,
    parameter int reset_cycles = 10
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;   // released on a falling edge like the other inputs.
    end

endmodule : tb_clock_gen

//--- lc3b_exec_top.sv
module lc3b_exec_top
#(
    parameter lc3b_types::lc3b_nzp cc_init = 3'b010
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  lc3b_types::lc3b_word instr,
    input  lc3b_types::lc3b_word npc,
    input  logic                 instr_valid,
    input  logic                 mem_stall,
    input  lc3b_types::lc3b_word mem_rdata,
    output lc3b_types::lc3b_word mem_addr,
    output lc3b_types::lc3b_word mem_wdata,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 wb_valid,
    output lc3b_types::lc3b_reg  wb_reg,
    output lc3b_types::lc3b_word wb_data,
    output lc3b_types::lc3b_nzp  cc,
    output logic                 stall
);
    import lc3b_types::*;

    lc3b_reg   rd_reg_a;
    lc3b_reg   rd_reg_b;
    lc3b_word  rd_data_a;
    lc3b_word  rd_data_b;
    lc3b_stage dec_stage;
    lc3b_stage ex_stage;
    logic      take;

    assign take = instr_valid & ~stall;

    lc3b_regfile regfile
    (
        .clk       (clk),
        .reset     (reset),
        .we        (wb_valid),
        .wr_reg    (wb_reg),
        .wr_data   (wb_data),
        .rd_reg_a  (rd_reg_a),
        .rd_reg_b  (rd_reg_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    lc3b_decode decode
    (
        .instr     (instr),
        .npc       (npc),
        .take      (take),
        .rd_reg_a  (rd_reg_a),
        .rd_reg_b  (rd_reg_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .stage     (dec_stage)
    );

    id_ex_latch latch
    (
        .clk       (clk),
        .reset     (reset),
        .hold      (stall),
        .in_stage  (dec_stage),
        .out_stage (ex_stage)
    );

    execute #(.cc_init(cc_init)) exec
    (
        .clk       (clk),
        .reset     (reset),
        .ex_stage  (ex_stage),
        .mem_stall (mem_stall),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .wb_valid  (wb_valid),
        .wb_reg    (wb_reg),
        .wb_data   (wb_data),
        .cc        (cc),
        .stall     (stall)
    );

endmodule : lc3b_exec_top

//--- execute.sv
module execute
#(
    parameter lc3b_types::lc3b_nzp cc_init = 3'b010
)
(
    input  logic                  clk,
    input  logic                  reset,
    input  lc3b_types::lc3b_stage ex_stage,
    input  logic                  mem_stall,
    input  lc3b_types::lc3b_word  mem_rdata,
    output lc3b_types::lc3b_word  mem_addr,
    output lc3b_types::lc3b_word  mem_wdata,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  wb_valid,
    output lc3b_types::lc3b_reg   wb_reg,
    output lc3b_types::lc3b_word  wb_data,
    output lc3b_types::lc3b_nzp   cc,
    output logic                  stall
);
    import lc3b_types::*;

    lc3b_control_word cw;
    logic             ind_phase;
    logic             ptr_cycle;
    lc3b_word         ptr_q;
    lc3b_word         base;
    lc3b_word         offset;
    lc3b_word         addr_sum;
    lc3b_word         alu_b;
    lc3b_word         alu_f;
    logic [5:0]       off6;
    logic [8:0]       off9;
    lc3b_nzp          wb_nzp;

    assign ptr_cycle = ex_stage.valid & ex_stage.cw.indirect & ~ind_phase;

    // second ldi/sti access runs as ldr/str at the saved pointer.
    always_comb
    begin
        cw = ex_stage.cw;
        if (ind_phase)
        begin
            cw.addr2mux_sel = addr2_zero;
        end
        else if (ex_stage.cw.indirect)
        begin
            cw.load_cc = 1'b0;
            cw.load_regfile = 1'b0;
            cw.mem_read = 1'b1;
            cw.mem_write = 1'b0;
        end
    end

    assign off6 = ex_stage.ir.off.low6;
    assign off9 = {ex_stage.ir.off.base, off6};

    always_comb
    begin
        if (ind_phase)
            base = ptr_q;
        else if (cw.addr1mux_sel == addr1_base)
            base = ex_stage.sr1_data;
        else
            base = ex_stage.npc;
        case (cw.addr2mux_sel)
            addr2_off6: offset = {{10{off6[5]}}, off6};
            addr2_off9: offset = {{7{off9[8]}}, off9};
            default:    offset = '0;
        endcase
        if (cw.lshf_enable)
            offset = offset << 1;
        addr_sum = base + offset;
    end

    always_comb
    begin
        case (cw.sr2mux_sel)
            sr2_imm5:   alu_b = {{11{ex_stage.ir.rr.imm5[4]}}, ex_stage.ir.rr.imm5};
            sr2_amount: alu_b = {12'h000, ex_stage.ir.off.low6.amount};
            default:    alu_b = ex_stage.sr2_data;
        endcase
    end

    lc3b_alu alu
    (
        .aluop (cw.aluop),
        .a     (ex_stage.sr1_data),
        .b     (alu_b),
        .f     (alu_f)
    );

    always_comb
    begin
        case (cw.regfilemux_sel)
            rf_mem:  wb_data = mem_rdata;
            rf_addr: wb_data = addr_sum;
            default: wb_data = alu_f;
        endcase
        if (wb_data[15])
            wb_nzp = 3'b100;
        else if (wb_data == '0)
            wb_nzp = 3'b010;
        else
            wb_nzp = 3'b001;
    end

    assign mem_addr = addr_sum;
    assign mem_wdata = ex_stage.sr2_data;
    assign mem_read = ex_stage.valid & cw.mem_read;
    assign mem_write = ex_stage.valid & cw.mem_write;
    assign wb_valid = ex_stage.valid & cw.load_regfile & ~mem_stall;
    assign wb_reg = ex_stage.dr;
    assign stall = mem_stall | ptr_cycle;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ind_phase <= 1'b0;
            cc <= cc_init;
        end
        else if (!mem_stall)
        begin
            ind_phase <= ptr_cycle;
            if (ex_stage.valid && cw.load_cc)
                cc <= wb_nzp;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ptr_cycle && !mem_stall)
            ptr_q <= mem_rdata;
    end

endmodule : execute

//--- lc3b_alu.sv
module lc3b_alu
(
    input  lc3b_types::lc3b_aluop aluop,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b,
    output lc3b_types::lc3b_word  f
);
    import lc3b_types::*;

    logic [3:0] shamt;

    assign shamt = b[3:0];

    always_comb
    begin
        case (aluop)
            alu_add:  f = a + b;
            alu_and:  f = a & b;
            alu_not:  f = ~a;
            alu_pass: f = a;
            alu_sll:  f = a << shamt;
            alu_srl:  f = a >> shamt;
            alu_sra:  f = $signed(a) >>> shamt;
            default:  f = a;
        endcase
    end

endmodule : lc3b_alu

//--- id_ex_latch.sv
module id_ex_latch
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  hold,
    input  lc3b_types::lc3b_stage in_stage,
    output lc3b_types::lc3b_stage out_stage
);
    import lc3b_types::*;

    lc3b_stage stage_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            stage_q.valid <= 1'b0;
        end
        else if (!hold)
        begin
            stage_q <= in_stage;
        end
    end

    assign out_stage = stage_q;

endmodule : id_ex_latch

//--- lc3b_decode.sv
module lc3b_decode
(
    input  lc3b_types::lc3b_word  instr,
    input  lc3b_types::lc3b_word  npc,
    input  logic                  take,
    output lc3b_types::lc3b_reg   rd_reg_a,
    output lc3b_types::lc3b_reg   rd_reg_b,
    input  lc3b_types::lc3b_word  rd_data_a,
    input  lc3b_types::lc3b_word  rd_data_b,
    output lc3b_types::lc3b_stage stage
);
    import lc3b_types::*;

    lc3b_instr        ir;
    lc3b_control_word cw;
    logic             supported;

    assign ir = instr;

    always_comb
    begin
        cw = '0;
        cw.opcode = ir.rr.opcode;
        cw.aluop = alu_pass;
        supported = 1'b1;
        case (ir.rr.opcode)
            op_add, op_and:
            begin
                cw.aluop = (ir.rr.opcode == op_add) ? alu_add : alu_and;
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.sr2mux_sel = ir.rr.imm ? sr2_imm5 : sr2_reg;
                cw.regfilemux_sel = rf_alu;
            end
            op_not:
            begin
                cw.aluop = alu_not;
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.regfilemux_sel = rf_alu;
            end
            op_shf:
            begin
                if (!ir.off.low6.shf_d)
                    cw.aluop = alu_sll;
                else if (ir.off.low6.shf_a)
                    cw.aluop = alu_sra;
                else
                    cw.aluop = alu_srl;
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.sr2mux_sel = sr2_amount;
                cw.regfilemux_sel = rf_alu;
            end
            op_lea:
            begin
                cw.load_regfile = 1'b1;     // lc-3b lea leaves the cc alone.
                cw.addr1mux_sel = addr1_npc;
                cw.addr2mux_sel = addr2_off9;
                cw.lshf_enable = 1'b1;
                cw.regfilemux_sel = rf_addr;
            end
            op_ldr, op_ldi:
            begin
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.mem_read = 1'b1;
                cw.addr1mux_sel = addr1_base;
                cw.addr2mux_sel = addr2_off6;
                cw.lshf_enable = 1'b1;
                cw.regfilemux_sel = rf_mem;
                cw.indirect = (ir.rr.opcode == op_ldi);
            end
            op_str, op_sti:
            begin
                cw.mem_write = 1'b1;
                cw.addr1mux_sel = addr1_base;
                cw.addr2mux_sel = addr2_off6;
                cw.lshf_enable = 1'b1;
                cw.indirect = (ir.rr.opcode == op_sti);
            end
            default:
            begin
                supported = 1'b0;
            end
        endcase
    end

    assign rd_reg_a = ir.rr.sr1;
    assign rd_reg_b = cw.mem_write ? ir.off.dr : ir.rr.imm5[2:0]; // stores read their data.

    always_comb
    begin
        stage.valid = take & supported;
        stage.cw = cw;
        stage.ir = ir;
        stage.npc = npc;
        stage.sr1_data = rd_data_a;
        stage.sr2_data = rd_data_b;
        stage.dr = ir.rr.dr;
    end

endmodule : lc3b_decode

//--- lc3b_regfile.sv
module lc3b_regfile
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 we,
    input  lc3b_types::lc3b_reg  wr_reg,
    input  lc3b_types::lc3b_word wr_data,
    input  lc3b_types::lc3b_reg  rd_reg_a,
    input  lc3b_types::lc3b_reg  rd_reg_b,
    output lc3b_types::lc3b_word rd_data_a,
    output lc3b_types::lc3b_word rd_data_b
);
    import lc3b_types::*;

    lc3b_word regs [8];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[wr_reg] <= wr_data;
        end
    end

    // a read of the register being written sees the new value.
    always_comb
    begin
        rd_data_a = (we && wr_reg == rd_reg_a) ? wr_data : regs[rd_reg_a];
        rd_data_b = (we && wr_reg == rd_reg_b) ? wr_data : regs[rd_reg_b];
    end

endmodule : lc3b_regfile

//--- lc3b_types.sv
package lc3b_types;

    typedef logic [15:0] lc3b_word;
    typedef logic [2:0]  lc3b_reg;
    typedef logic [2:0]  lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef enum logic [1:0] {sr2_reg, sr2_imm5, sr2_amount} lc3b_sr2sel;
    typedef enum logic {addr1_npc, addr1_base} lc3b_addr1sel;
    typedef enum logic [1:0] {addr2_zero, addr2_off6, addr2_off9} lc3b_addr2sel;
    typedef enum logic [1:0] {rf_alu, rf_mem, rf_addr} lc3b_rfsel;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    sr1;
        logic       imm;
        logic [4:0] imm5;           // sr2 sits in the low three bits.
    } lc3b_instr_rr;

    typedef struct packed {
        logic       shf_a;
        logic       shf_d;
        logic [3:0] amount;
    } lc3b_low6;                    // also read whole as offset6.

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;             // source register for stores.
        lc3b_reg    base;
        lc3b_low6   low6;
    } lc3b_instr_off;

    typedef union packed {
        lc3b_instr_rr  rr;
        lc3b_instr_off off;
    } lc3b_instr;

    typedef struct packed {
        lc3b_opcode   opcode;
        lc3b_aluop    aluop;
        logic         load_cc;
        logic         load_regfile;
        logic         mem_read;
        logic         mem_write;
        lc3b_sr2sel   sr2mux_sel;
        lc3b_addr1sel addr1mux_sel;
        lc3b_addr2sel addr2mux_sel;
        logic         lshf_enable;
        lc3b_rfsel    regfilemux_sel;
        logic         indirect;
    } lc3b_control_word;

    typedef struct packed {
        logic             valid;
        lc3b_control_word cw;
        lc3b_instr        ir;
        lc3b_word         npc;
        lc3b_word         sr1_data;
        lc3b_word         sr2_data;
        lc3b_reg          dr;
    } lc3b_stage;

endpackage : lc3b_types
